// ==== hdl/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

	// Data word and register index
	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;

	// RV32I base opcodes
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

	// Memory sizes in words, map in bytes
	localparam int ROM_WORDS = 64;
	localparam int RAM_WORDS = 128;
	localparam int ROM_AW = $clog2(ROM_WORDS);
	localparam int RAM_AW = $clog2(RAM_WORDS);
	localparam word_t RAM_LIMIT = word_t'(RAM_WORDS * 4);
	localparam word_t PORT_ADDR = 32'h0000_0400;
	localparam word_t RESET_PC = 32'h0000_0000;
	localparam string ROM_FILE = "sim/program.hex";

	// ALU class, refined in execute by funct3 and funct7
	localparam logic [1:0] ALU_CLASS_ADD = 2'd0;
	localparam logic [1:0] ALU_CLASS_SUB = 2'd1;
	localparam logic [1:0] ALU_CLASS_REG = 2'd2;
	localparam logic [1:0] ALU_CLASS_IMM = 2'd3;

	// Instruction formats, MSB first
	typedef struct packed {
		logic [6:0] funct7;
		reg_addr_t rs2;
		reg_addr_t rs1;
		logic [2:0] funct3;
		reg_addr_t rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm_11_0;
		reg_addr_t rs1;
		logic [2:0] funct3;
		reg_addr_t rd;
		logic [6:0] opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_11_5;
		reg_addr_t rs2;
		reg_addr_t rs1;
		logic [2:0] funct3;
		logic [4:0] imm_4_0;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic imm_12;
		logic [5:0] imm_10_5;
		reg_addr_t rs2;
		reg_addr_t rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic imm_11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm_31_12;
		reg_addr_t rd;
		logic [6:0] opcode;
	} u_fmt_t;

	typedef struct packed {
		logic imm_20;
		logic [9:0] imm_10_1;
		logic imm_11;
		logic [7:0] imm_19_12;
		reg_addr_t rd;
		logic [6:0] opcode;
	} j_fmt_t;

	// One word, six views
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} instr_u;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
		ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
	} alu_op_e;

	typedef enum logic [1:0] {
		WB_ALU = 2'd0,
		WB_MEM = 2'd1,
		WB_PC4 = 2'd2,
		WB_IMM = 2'd3
	} wb_sel_e;

	// All zero means bubble
	typedef struct packed {
		logic alu_src_a_pc;
		logic alu_src_b_imm;
		logic [1:0] alu_class;
		logic jump;
		logic jalr;
		logic branch;
		logic branch_ne;
		logic mem_read;
		logic mem_write;
		logic reg_write;
		wb_sel_e wb_sel;
	} ctrl_t;

	typedef struct packed {
		word_t pc;
		word_t instr;
	} if_id_t;

	typedef struct packed {
		ctrl_t ctrl;
		word_t pc;
		word_t rs1_data;
		word_t rs2_data;
		word_t imm;
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rd;
		logic [2:0] funct3;
		logic funct7_b5;
	} id_ex_t;

	typedef struct packed {
		ctrl_t ctrl;
		word_t pc;
		word_t alu_result;
		word_t store_data;
		word_t imm;
		reg_addr_t rd;
	} ex_mem_t;

	typedef struct packed {
		logic reg_write;
		wb_sel_e wb_sel;
		word_t pc;
		word_t alu_result;
		word_t mem_data;
		word_t imm;
		reg_addr_t rd;
	} mem_wb_t;

	// Result heading back to earlier stages
	typedef struct packed {
		logic valid;
		reg_addr_t rd;
		word_t value;
	} fwd_t;

endpackage

`default_nettype wire

// ==== hdl/fetch_stage.sv ====
`default_nettype none

module fetch_stage import rv_pkg::*; (
	input  logic   i_clk,
	input  logic   i_reset,
	input  logic   i_stall,
	input  logic   i_jump_seen,
	input  logic   i_redirect,
	input  word_t  i_target,
	output if_id_t o_if_id
);

	// Program store, read asynchronously from the PC
	word_t rom [ROM_WORDS];

	word_t pc;
	word_t fetched;
	logic jump_delay;
	logic bubble;

	initial begin
		$readmemh(ROM_FILE, rom);
	end

	assign fetched = rom[pc[ROM_AW+1:2]];

	// Two bubbles per control transfer, this cycle and the next
	assign bubble = i_jump_seen | jump_delay;

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			jump_delay <= 1'b0;
		end else begin
			jump_delay <= i_jump_seen;
		end
	end

	// Redirect wins over everything
	// PC waits during bubbles so a not-taken branch resumes at its successor
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			pc <= RESET_PC;
		end else if (i_redirect) begin
			pc <= i_target;
		end else if (!i_stall && !bubble) begin
			pc <= pc + 32'd4;
		end
	end

	// IF/ID, held while decode stalls
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_if_id.instr <= '0;
		end else if (!i_stall) begin
			o_if_id.pc <= pc;
			// Opcode zero decodes to no control
			o_if_id.instr <= bubble ? '0 : fetched;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/decode_stage.sv ====
`default_nettype none

module decode_stage import rv_pkg::*; (
	input  logic   i_clk,
	input  logic   i_reset,
	input  if_id_t i_if_id,
	input  fwd_t   i_wb,
	output logic   o_stall,
	output logic   o_jump_seen,
	output id_ex_t o_id_ex
);

	word_t regs [32];

	instr_u ins;
	ctrl_t ctrl;
	word_t imm;
	logic uses_rs1;
	logic uses_rs2;
	reg_addr_t rs1;
	reg_addr_t rs2;
	word_t rs1_data;
	word_t rs2_data;

	assign ins = i_if_id.instr;

	// Control and immediate by format
	always_comb begin
		ctrl = '0;
		imm = '0;
		uses_rs1 = 1'b0;
		uses_rs2 = 1'b0;
		case (ins.r.opcode)
			OPC_OP: begin
				ctrl.alu_class = ALU_CLASS_REG;
				ctrl.reg_write = 1'b1;
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
			end
			OPC_OP_IMM, OPC_LOAD, OPC_JALR: begin
				imm = {{20{ins.i.imm_11_0[11]}}, ins.i.imm_11_0};
				ctrl.alu_class = (ins.r.opcode == OPC_OP_IMM) ? ALU_CLASS_IMM : ALU_CLASS_ADD;
				ctrl.alu_src_b_imm = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.mem_read = (ins.r.opcode == OPC_LOAD);
				ctrl.jump = (ins.r.opcode == OPC_JALR);
				ctrl.jalr = (ins.r.opcode == OPC_JALR);
				if (ins.r.opcode == OPC_LOAD) begin
					ctrl.wb_sel = WB_MEM;
				end else if (ins.r.opcode == OPC_JALR) begin
					ctrl.wb_sel = WB_PC4;
				end
				uses_rs1 = 1'b1;
			end
			OPC_STORE: begin
				imm = {{20{ins.s.imm_11_5[6]}}, ins.s.imm_11_5, ins.s.imm_4_0};
				ctrl.alu_src_b_imm = 1'b1;
				ctrl.mem_write = 1'b1;
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
			end
			OPC_BRANCH: begin
				imm = {{19{ins.b.imm_12}}, ins.b.imm_12, ins.b.imm_11,
					ins.b.imm_10_5, ins.b.imm_4_1, 1'b0};
				// Compare by subtraction, BNE is funct3 bit 0
				ctrl.alu_class = ALU_CLASS_SUB;
				ctrl.branch = 1'b1;
				ctrl.branch_ne = ins.b.funct3[0];
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
			end
			OPC_JAL: begin
				imm = {{11{ins.j.imm_20}}, ins.j.imm_20, ins.j.imm_19_12,
					ins.j.imm_11, ins.j.imm_10_1, 1'b0};
				ctrl.jump = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.wb_sel = WB_PC4;
			end
			OPC_LUI, OPC_AUIPC: begin
				imm = {ins.u.imm_31_12, 12'b0};
				ctrl.reg_write = 1'b1;
				// AUIPC adds to PC in the ALU, LUI takes imm straight
				ctrl.alu_src_a_pc = 1'b1;
				ctrl.alu_src_b_imm = 1'b1;
				ctrl.wb_sel = (ins.u.opcode == OPC_LUI) ? WB_IMM : WB_ALU;
			end
			default: begin
				ctrl = '0;
			end
		endcase
	end

	// Unused source fields become x0 so they never match
	assign rs1 = uses_rs1 ? ins.r.rs1 : '0;
	assign rs2 = uses_rs2 ? ins.r.rs2 : '0;

	// Register file, written at the end of WB
	always_ff @(posedge i_clk) begin
		if (i_wb.valid && i_wb.rd != '0) begin
			regs[i_wb.rd] <= i_wb.value;
		end
	end

	// Same-cycle WB write seen through bypass; x0 reads zero
	always_comb begin
		if (rs1 == '0) begin
			rs1_data = '0;
		end else if (i_wb.valid && i_wb.rd == rs1) begin
			rs1_data = i_wb.value;
		end else begin
			rs1_data = regs[rs1];
		end
		if (rs2 == '0) begin
			rs2_data = '0;
		end else if (i_wb.valid && i_wb.rd == rs2) begin
			rs2_data = i_wb.value;
		end else begin
			rs2_data = regs[rs2];
		end
	end

	// Load in EX feeding this instruction
	assign o_stall = o_id_ex.ctrl.mem_read && o_id_ex.rd != '0
		&& (o_id_ex.rd == rs1 || o_id_ex.rd == rs2);

	assign o_jump_seen = (ctrl.jump | ctrl.branch) & ~o_stall;

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_id_ex.ctrl <= '0;
		end else begin
			o_id_ex.ctrl <= o_stall ? '0 : ctrl;
			o_id_ex.pc <= i_if_id.pc;
			o_id_ex.rs1_data <= rs1_data;
			o_id_ex.rs2_data <= rs2_data;
			o_id_ex.imm <= imm;
			o_id_ex.rs1 <= rs1;
			o_id_ex.rs2 <= rs2;
			o_id_ex.rd <= ins.r.rd;
			o_id_ex.funct3 <= ins.r.funct3;
			o_id_ex.funct7_b5 <= ins.r.funct7[5];
		end
	end

endmodule

`default_nettype wire

// ==== hdl/execute_stage.sv ====
`default_nettype none

module execute_stage import rv_pkg::*; (
	input  logic    i_clk,
	input  logic    i_reset,
	input  id_ex_t  i_id_ex,
	input  fwd_t    i_mem_fwd,
	input  fwd_t    i_wb_fwd,
	output logic    o_redirect,
	output word_t   o_target,
	output ex_mem_t o_ex_mem
);

	word_t rs1_val;
	word_t rs2_val;
	word_t op_a;
	word_t op_b;
	word_t alu_result;
	logic alu_zero;
	alu_op_e alu_op;
	word_t jalr_sum;

	// Youngest producer wins, x0 is never forwarded
	function automatic word_t fwd_value(
		input reg_addr_t rs,
		input word_t reg_val,
		input fwd_t mem_fwd,
		input fwd_t wb_fwd
	);
		word_t val;
		val = reg_val;
		if (wb_fwd.valid && wb_fwd.rd == rs && rs != '0) begin
			val = wb_fwd.value;
		end
		if (mem_fwd.valid && mem_fwd.rd == rs && rs != '0) begin
			val = mem_fwd.value;
		end
		return val;
	endfunction

	assign rs1_val = fwd_value(i_id_ex.rs1, i_id_ex.rs1_data, i_mem_fwd, i_wb_fwd);
	// Also the store data
	assign rs2_val = fwd_value(i_id_ex.rs2, i_id_ex.rs2_data, i_mem_fwd, i_wb_fwd);

	assign op_a = i_id_ex.ctrl.alu_src_a_pc ? i_id_ex.pc : rs1_val;
	assign op_b = i_id_ex.ctrl.alu_src_b_imm ? i_id_ex.imm : rs2_val;

	// ALU operation from class, funct3 and funct7 bit 5
	always_comb begin
		alu_op = ALU_ADD;
		case (i_id_ex.ctrl.alu_class)
			ALU_CLASS_SUB: alu_op = ALU_SUB;
			ALU_CLASS_REG, ALU_CLASS_IMM: begin
				case (i_id_ex.funct3)
					// ADDI has no subtract form
					3'b000: alu_op = (i_id_ex.ctrl.alu_class == ALU_CLASS_REG
						&& i_id_ex.funct7_b5) ? ALU_SUB : ALU_ADD;
					3'b001: alu_op = ALU_SLL;
					3'b010: alu_op = ALU_SLT;
					3'b011: alu_op = ALU_SLTU;
					3'b100: alu_op = ALU_XOR;
					3'b101: alu_op = i_id_ex.funct7_b5 ? ALU_SRA : ALU_SRL;
					3'b110: alu_op = ALU_OR;
					default: alu_op = ALU_AND;
				endcase
			end
			default: alu_op = ALU_ADD;
		endcase
	end

	always_comb begin
		case (alu_op)
			ALU_SUB:  alu_result = op_a - op_b;
			ALU_AND:  alu_result = op_a & op_b;
			ALU_OR:   alu_result = op_a | op_b;
			ALU_XOR:  alu_result = op_a ^ op_b;
			ALU_SLT:  alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
			ALU_SLTU: alu_result = {31'b0, op_a < op_b};
			ALU_SLL:  alu_result = op_a << op_b[4:0];
			ALU_SRL:  alu_result = op_a >> op_b[4:0];
			ALU_SRA:  alu_result = $signed(op_a) >>> op_b[4:0];
			default:  alu_result = op_a + op_b;
		endcase
	end

	assign alu_zero = (alu_result == '0);

	// Branch resolves here, equality via the zero flag
	assign o_redirect = i_id_ex.ctrl.jump
		| (i_id_ex.ctrl.branch & (alu_zero ^ i_id_ex.ctrl.branch_ne));

	// JALR clears bit 0
	assign jalr_sum = rs1_val + i_id_ex.imm;
	assign o_target = i_id_ex.ctrl.jalr ? {jalr_sum[31:1], 1'b0} : i_id_ex.pc + i_id_ex.imm;

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_ex_mem.ctrl <= '0;
		end else begin
			o_ex_mem.ctrl <= i_id_ex.ctrl;
			o_ex_mem.pc <= i_id_ex.pc;
			o_ex_mem.alu_result <= alu_result;
			o_ex_mem.store_data <= rs2_val;
			o_ex_mem.imm <= i_id_ex.imm;
			o_ex_mem.rd <= i_id_ex.rd;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/mem_wb_stage.sv ====
`default_nettype none

module mem_wb_stage import rv_pkg::*; (
	input  logic    i_clk,
	input  logic    i_reset,
	input  ex_mem_t i_ex_mem,
	output fwd_t    o_mem_fwd,
	output fwd_t    o_wb,
	output word_t   o_port_data,
	output logic    o_port_write
);

	word_t ram [RAM_WORDS];

	logic ram_sel;
	logic port_sel;
	logic [RAM_AW-1:0] ram_idx;
	word_t mem_data;
	mem_wb_t mem_wb;

	// Writeback source mux, shared by the MEM forward and WB
	function automatic word_t wb_value(
		input wb_sel_e sel,
		input word_t alu,
		input word_t mem,
		input word_t pc,
		input word_t imm
	);
		case (sel)
			WB_MEM:  return mem;
			WB_PC4:  return pc + 32'd4;
			WB_IMM:  return imm;
			default: return alu;
		endcase
	endfunction

	// Address decode, word aligned
	assign ram_sel = (i_ex_mem.alu_result < RAM_LIMIT);
	assign port_sel = (i_ex_mem.alu_result == PORT_ADDR);
	assign ram_idx = i_ex_mem.alu_result[RAM_AW+1:2];

	always_ff @(posedge i_clk) begin
		if (i_ex_mem.ctrl.mem_write && ram_sel) begin
			ram[ram_idx] <= i_ex_mem.store_data;
		end
	end

	// Port reads back its last value
	always_comb begin
		mem_data = '0;
		if (i_ex_mem.ctrl.mem_read && ram_sel) begin
			mem_data = ram[ram_idx];
		end else if (i_ex_mem.ctrl.mem_read && port_sel) begin
			mem_data = o_port_data;
		end
	end

	// Output port, one-cycle write strobe
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_port_write <= 1'b0;
		end else begin
			o_port_write <= i_ex_mem.ctrl.mem_write & port_sel;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_ex_mem.ctrl.mem_write && port_sel) begin
			o_port_data <= i_ex_mem.store_data;
		end
	end

	// Load data is not ready here, load-use stall covers it
	always_comb begin
		o_mem_fwd.valid = i_ex_mem.ctrl.reg_write & ~i_ex_mem.ctrl.mem_read;
		o_mem_fwd.rd = i_ex_mem.rd;
		o_mem_fwd.value = wb_value(i_ex_mem.ctrl.wb_sel, i_ex_mem.alu_result, mem_data,
			i_ex_mem.pc, i_ex_mem.imm);
	end

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			mem_wb.reg_write <= 1'b0;
		end else begin
			mem_wb.reg_write <= i_ex_mem.ctrl.reg_write;
			mem_wb.wb_sel <= i_ex_mem.ctrl.wb_sel;
			mem_wb.pc <= i_ex_mem.pc;
			mem_wb.alu_result <= i_ex_mem.alu_result;
			mem_wb.mem_data <= mem_data;
			mem_wb.imm <= i_ex_mem.imm;
			mem_wb.rd <= i_ex_mem.rd;
		end
	end

	// Register file write port
	always_comb begin
		o_wb.valid = mem_wb.reg_write;
		o_wb.rd = mem_wb.rd;
		o_wb.value = wb_value(mem_wb.wb_sel, mem_wb.alu_result, mem_wb.mem_data,
			mem_wb.pc, mem_wb.imm);
	end

endmodule

`default_nettype wire

// ==== hdl/risc_v_top.sv ====
`default_nettype none

module risc_v_top import rv_pkg::*; (
	input  logic  i_clk,
	input  logic  i_reset,
	output word_t o_port_data,
	output logic  o_port_write
);

	// Pipeline registers between stages
	if_id_t if_id;
	id_ex_t id_ex;
	ex_mem_t ex_mem;

	// Results fed back for forwarding and register write
	fwd_t mem_fwd;
	fwd_t wb_fwd;

	// Fetch steering
	logic stall;
	logic jump_seen;
	logic redirect;
	word_t target;

	fetch_stage u_fetch (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_stall     (stall),
		.i_jump_seen (jump_seen),
		.i_redirect  (redirect),
		.i_target    (target),
		.o_if_id     (if_id)
	);

	decode_stage u_decode (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_if_id     (if_id),
		.i_wb        (wb_fwd),
		.o_stall     (stall),
		.o_jump_seen (jump_seen),
		.o_id_ex     (id_ex)
	);

	execute_stage u_execute (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_id_ex    (id_ex),
		.i_mem_fwd  (mem_fwd),
		.i_wb_fwd   (wb_fwd),
		.o_redirect (redirect),
		.o_target   (target),
		.o_ex_mem   (ex_mem)
	);

	// Memory, output port and writeback
	mem_wb_stage u_mem_wb (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_ex_mem     (ex_mem),
		.o_mem_fwd    (mem_fwd),
		.o_wb         (wb_fwd),
		.o_port_data  (o_port_data),
		.o_port_write (o_port_write)
	);

endmodule

`default_nettype wire

// ==== sim/tb_risc_v_top.sv ====
`default_nettype none

module tb_risc_v_top import rv_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	// Operand that the program loads into x1
	localparam word_t OP_A = 32'd90;

	// Program addresses of JAL, JALR and AUIPC
	localparam word_t JAL_PC = 32'h0000_00A0;
	localparam word_t JALR_PC = 32'h0000_00AC;
	localparam word_t AUIPC_PC = 32'h0000_00C0;

	logic clk;
	logic reset;
	word_t port_data;
	logic port_write;

	int cycles = 0;
	int cycle_limit = 0;

	// Expected port writes in program order
	string labels [$];
	word_t expected [$];

	risc_v_top DUT (
		.i_clk        (clk),
		.i_reset      (reset),
		.o_port_data  (port_data),
		.o_port_write (port_write)
	);

	// 100 ns period
	always #50 clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input word_t exp_val, input word_t act_val);
		if (act_val !== exp_val) begin
			abort_run($sformatf("Mismatch at %0t: %s expected %h, got %h",
				$time, name, exp_val, act_val));
		end
	endtask

	task automatic check_bit(input string name, input logic exp_val, input logic act_val);
		if (act_val !== exp_val) begin
			abort_run($sformatf("Mismatch at %0t: %s expected %b, got %b",
				$time, name, exp_val, act_val));
		end
	endtask

	task automatic add_entry(input string label, input word_t value);
		labels.push_back(label);
		expected.push_back(value);
	endtask

	// Values worked out from the RV32I rules for each program step
	task automatic build_table();
		// 5 + 7 forwarded and then x1 added
		add_entry("ADD chain", 32'd5 + 32'd7 + OP_A);
		// x1 holds 90 (0x5a) and x2 holds -7 (0xfffffff9)
		add_entry("SUB", 32'h0000_0061);
		// Low byte 0x5a against 0xf9
		add_entry("AND", 32'h0000_0058);
		add_entry("OR", 32'hFFFF_FFFB);
		add_entry("XOR", 32'hFFFF_FFA3);
		// Signed -7 is below 90
		add_entry("SLT", 32'd1);
		// Unsigned 0xfffffff9 is above 90
		add_entry("SLTU", 32'd0);
		add_entry("SLLI", 32'hFFFF_FF90);
		add_entry("SRLI", 32'h0FFF_FFFF);
		// Arithmetic shift rounds -7 / 2 down to -4
		add_entry("SRAI", 32'hFFFF_FFFC);
		// Stored x1 read back and 100 added
		add_entry("LW then ADDI", OP_A + 32'd100);
		// Only the adds behind not-taken branches count
		add_entry("branches", 32'd1 + 32'd2 + 32'd16);
		add_entry("JAL link", JAL_PC + 32'd4);
		add_entry("JALR link", JALR_PC + 32'd4);
		add_entry("LUI", {20'h12345, 12'h000});
		add_entry("AUIPC", AUIPC_PC + {20'h00001, 12'h000});
	endtask

	// One-cycle strobe sampled mid-cycle
	task automatic wait_port_write();
		@(negedge clk);
		while (!port_write) begin
			@(negedge clk);
		end
	endtask

	// Run length guard
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			abort_run($sformatf("Timeout: expected port writes not seen within %0d cycles",
				cycle_limit));
		end
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		build_table();
		// Reset, fill and 40 cycles per write
		cycle_limit = 20 + 40 * expected.size();

		// 4 cycles of reset released just after the edge
		repeat (4) @(posedge clk);
		#1 reset = 1'b0;

		foreach (expected[i]) begin
			wait_port_write();
			check_word($sformatf("o_port_data [%0d %s]", i, labels[i]), expected[i], port_data);
		end

		// Program now spins on its self-jump
		repeat (50) begin
			@(negedge clk);
			check_bit("o_port_write after last value", 1'b0, port_write);
		end

		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/program.hex ====
// One RV32I instruction word per line, in hex, starting at byte address 0
// Results go to the output port at 0x400 through x31
40000F93
05A00093
FF900113
00500213
00700293
00520233
00120233
004FA023
402081B3
003FA023
0020F1B3
003FA023
0020E1B3
003FA023
0020C1B3
003FA023
001121B3
003FA023
001131B3
003FA023
00411193
003FA023
00415193
003FA023
40115193
003FA023
00102423
00802283
06428293
005FA023
00100313
00208463
00230313
00109463
01030313
00209463
00430313
00630463
00830313
006FA023
008003EF
00000393
007FA023
010384E7
00000493
009FA023
12345537
00AFA023
00001597
00BFA023
0000006F

// ==== sim.f ====
hdl/rv_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/mem_wb_stage.sv
hdl/risc_v_top.sv
sim/tb_risc_v_top.sv

// ==== Makefile ====
# Verilator build and run of the RV32I pipeline testbench

VERILATOR ?= verilator
TOP       ?= tb_risc_v_top
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timescale 1ns/100ps

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Runs from the project root so the ROM image path resolves
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
